// File: pi1_consts.svh
`ifndef PI1_CONSTS_SVH
`define PI1_CONSTS_SVH

// Bus widths
`define PI1_ARCHBITSZ 32
`define PI1_ADDRBITSZ 30
`define PI1_SELBITSZ 4

`define GPIOCOUNT 8
// Stretch length is 2**width - 1 cycles
`define RST_CNTR_BITSZ 4

// Window sizes in words
`define DEVTBL_MAPSZ 16
`define GPIO_MAPSZ 4
`define INVALID_MAPSZ 1024

// Device ids and interrupt use flags
`define DEVTBL_ID 7
`define GPIO_ID 6
`define INVALID_ID 0
`define DEVTBL_USEINTR 0
`define GPIO_USEINTR 1
`define INVALID_USEINTR 0

`define SOCID 3
`define DEVTBL_SOCID_OFS 14
`define DEVTBL_RSTCTRL_OFS 15
`define GPIO_OUT_OFS 0
`define GPIO_IN_OFS 1
`define SLAVECOUNT 3

`endif

// File: pi1_pkg.sv
`include "pi1_consts.svh"

package pi1_pkg;

	// Same encoding as the pi1 op lines
	typedef enum logic [1:0] {
		pi1_noop  = 2'b00,
		pi1_write = 2'b01,
		pi1_read  = 2'b10,
		pi1_rdwr  = 2'b11
	} pi1_op_e;

	typedef struct packed {
		pi1_op_e                    op;
		logic [`PI1_ADDRBITSZ-1:0] addr;
		logic [`PI1_ARCHBITSZ-1:0] data;
		logic [`PI1_SELBITSZ-1:0]  sel;
	} pi1_req_t;

	typedef struct packed {
		logic [`PI1_ARCHBITSZ-1:0] rdata;
		logic                      rdy;
	} pi1_rsp_t;

	// Slave order on the router, also the device table order
	typedef enum logic [1:0] {
		slv_devtbl  = 2'd0,
		slv_gpio    = 2'd1,
		slv_invalid = 2'd2
	} slv_idx_t;

	typedef logic [`RST_CNTR_BITSZ-1:0] rst_cntr_t;

	// Read-write is handled as a plain read
	function automatic logic op_is_read(pi1_op_e op);
		return (op == pi1_read) || (op == pi1_rdwr);
	endfunction

	function automatic logic op_is_write(pi1_op_e op);
		return op == pi1_write;
	endfunction

endpackage

// File: reset_seq.sv
`timescale 1ns/10ps
`include "pi1_consts.svh"

module reset_seq import pi1_pkg::*; (
	input  logic clk_2x_w,
	input  logic rst_p,
	input  logic rst0_i,
	input  logic rst1_i,
	output logic sys_rst_o
);

	logic      sw_warm_rst;
	logic      sw_cold_rst;
	logic      sw_pwr_off;
	rst_cntr_t rst_cntr_q;
	logic      pwr_off_q;

	// Decode of the two reset control bits
	assign sw_warm_rst = !rst0_i && rst1_i;
	// Without a global reset primitive a cold reset runs the warm sequence
	assign sw_cold_rst = rst0_i && rst1_i;
	assign sw_pwr_off  = rst0_i && !rst1_i;

	// Stretch counter, held at all ones while any reset source is active
	always_ff @(posedge clk_2x_w) begin
		if (rst_p || sw_warm_rst || sw_cold_rst) begin
			rst_cntr_q <= '1;
		end else if (rst_cntr_q != '0) begin
			rst_cntr_q <= rst_cntr_q - 1'b1;
		end
	end

	// Power-off latch, only the external reset brings the system back
	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			pwr_off_q <= 1'b0;
		end else if (sw_pwr_off) begin
			pwr_off_q <= 1'b1;
		end
	end

	assign sys_rst_o = (rst_cntr_q != '0) || pwr_off_q;

	// The table drops its reset request bits once the system reset is active
	a_req_cleared: assert property (@(posedge clk_2x_w)
		sys_rst_o |=> !rst0_i && !rst1_i)
		else $error("Reset request bits not cleared by the system reset");

endmodule

// File: bus_router.sv
`timescale 1ns/10ps
`include "pi1_consts.svh"

module bus_router import pi1_pkg::*; (
	input  logic                      clk_2x_w,
	input  logic                      sys_rst_i,
	input  pi1_req_t                  req_i,
	output pi1_rsp_t                  rsp_o,
	output pi1_req_t                  devtbl_req_o,
	output pi1_req_t                  gpio_req_o,
	input  logic [`PI1_ARCHBITSZ-1:0] devtbl_rdata_i,
	input  logic [`PI1_ARCHBITSZ-1:0] gpio_rdata_i
);

	// Windows follow each other from address 0
	localparam logic [`PI1_ADDRBITSZ-1:0] devtbl_base = '0;
	localparam logic [`PI1_ADDRBITSZ-1:0] gpio_base   = devtbl_base + `DEVTBL_MAPSZ;
	localparam logic [`PI1_ADDRBITSZ-1:0] gpio_end    = gpio_base + `GPIO_MAPSZ;

	slv_idx_t sel_idx;
	slv_idx_t rd_idx_q;
	logic     rdy_w;
	logic     accept_w;

	always_comb begin
		if (req_i.addr < gpio_base) begin
			sel_idx = slv_devtbl;
		end else if (req_i.addr < gpio_end) begin
			sel_idx = slv_gpio;
		end else begin
			// Everything else falls into the invalid device
			sel_idx = slv_invalid;
		end
	end

	assign rdy_w    = !sys_rst_i;
	assign accept_w = (req_i.op != pi1_noop) && rdy_w;

	// Only the selected slave sees the op, with a window-relative address
	always_comb begin
		devtbl_req_o      = req_i;
		devtbl_req_o.addr = req_i.addr - devtbl_base;
		devtbl_req_o.op   = (accept_w && sel_idx == slv_devtbl) ? req_i.op : pi1_noop;
		gpio_req_o        = req_i;
		gpio_req_o.addr   = req_i.addr - gpio_base;
		gpio_req_o.op     = (accept_w && sel_idx == slv_gpio) ? req_i.op : pi1_noop;
	end

	// Remember where the last read went so its data can be returned
	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			rd_idx_q <= slv_invalid;
		end else if (accept_w && op_is_read(req_i.op)) begin
			rd_idx_q <= sel_idx;
		end
	end

	always_comb begin
		rsp_o.rdy = rdy_w;
		case (rd_idx_q)
			slv_devtbl: rsp_o.rdata = devtbl_rdata_i;
			slv_gpio:   rsp_o.rdata = gpio_rdata_i;
			// Invalid device reads as zero
			default:    rsp_o.rdata = '0;
		endcase
	end

	// Returned word holds until the next accepted read
	a_rdata_hold: assert property (@(posedge clk_2x_w)
		!sys_rst_i && !(accept_w && op_is_read(req_i.op)) |=> $stable(rsp_o.rdata))
		else $error("Read data changed without an accepted read");

	a_rdata_rst: assert property (@(posedge clk_2x_w)
		sys_rst_i |=> devtbl_rdata_i == '0 && gpio_rdata_i == '0)
		else $error("Slave read data not cleared by the system reset");

endmodule

// File: dev_table.sv
`timescale 1ns/10ps
`include "pi1_consts.svh"

module dev_table import pi1_pkg::*; (
	input  logic                      clk_2x_w,
	input  logic                      sys_rst_i,
	input  pi1_req_t                  req_i,
	output logic [`PI1_ARCHBITSZ-1:0] rdata_o,
	output logic                      rst0_o,
	output logic                      rst1_o
);

	// Per-slave entries in router order
	localparam logic [`PI1_ARCHBITSZ-1:0] map_sz [`SLAVECOUNT] =
		'{`DEVTBL_MAPSZ, `GPIO_MAPSZ, `INVALID_MAPSZ};
	localparam logic [15:0] dev_id [`SLAVECOUNT] =
		'{`DEVTBL_ID, `GPIO_ID, `INVALID_ID};
	localparam logic use_intr [`SLAVECOUNT] =
		'{`DEVTBL_USEINTR, `GPIO_USEINTR, `INVALID_USEINTR};

	logic [`PI1_ARCHBITSZ-1:0] tbl_word;
	logic                      rst0_q;
	logic                      rst1_q;

	always_comb begin
		tbl_word = '0;
		// Even offset holds the map size, odd offset the id and intr flag
		for (int k = 0; k < `SLAVECOUNT; k++) begin
			if (req_i.addr == 2 * k) begin
				tbl_word = map_sz[k];
			end
			if (req_i.addr == 2 * k + 1) begin
				tbl_word = {15'd0, use_intr[k], dev_id[k]};
			end
		end
		if (req_i.addr == `DEVTBL_SOCID_OFS) begin
			tbl_word = `PI1_ARCHBITSZ'(`SOCID);
		end
		if (req_i.addr == `DEVTBL_RSTCTRL_OFS) begin
			tbl_word = {30'd0, rst1_q, rst0_q};
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			rdata_o <= '0;
		end else if (op_is_read(req_i.op)) begin
			rdata_o <= tbl_word;
		end
	end

	// Reset control register, cleared by the reset it requests
	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			rst0_q <= 1'b0;
			rst1_q <= 1'b0;
		end else if (op_is_write(req_i.op) && req_i.addr == `DEVTBL_RSTCTRL_OFS
				&& req_i.sel[0]) begin
			rst0_q <= req_i.data[0];
			rst1_q <= req_i.data[1];
		end
	end

	assign rst0_o = rst0_q;
	assign rst1_o = rst1_q;

endmodule

// File: gpio_port.sv
`timescale 1ns/10ps
`include "pi1_consts.svh"

module gpio_port import pi1_pkg::*; (
	input  logic                      clk_2x_w,
	input  logic                      sys_rst_i,
	input  pi1_req_t                  req_i,
	output logic [`PI1_ARCHBITSZ-1:0] rdata_o,
	input  logic [`GPIOCOUNT-1:0]     gp_i,
	output logic [`GPIOCOUNT-1:0]     gp_o
);

	localparam int pad_bits = `PI1_ARCHBITSZ - `GPIOCOUNT;

	logic [`GPIOCOUNT-1:0] out_q;
	logic [`GPIOCOUNT-1:0] in_meta_q;
	logic [`GPIOCOUNT-1:0] in_sync_q;

	// Output register, byte lane 0 only
	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			out_q <= '0;
		end else if (op_is_write(req_i.op) && req_i.addr == `GPIO_OUT_OFS && req_i.sel[0]) begin
			out_q <= req_i.data[`GPIOCOUNT-1:0];
		end
	end

	// Pins are asynchronous to the bus clock
	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			in_meta_q <= '0;
			in_sync_q <= '0;
		end else begin
			in_meta_q <= gp_i;
			in_sync_q <= in_meta_q;
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			rdata_o <= '0;
		end else if (op_is_read(req_i.op)) begin
			case (req_i.addr)
				`GPIO_OUT_OFS: rdata_o <= {{pad_bits{1'b0}}, out_q};
				`GPIO_IN_OFS:  rdata_o <= {{pad_bits{1'b0}}, in_sync_q};
				default:       rdata_o <= '0;
			endcase
		end
	end

	assign gp_o = out_q;

endmodule

// File: pi1_soc.sv
`timescale 1ns/10ps
`include "pi1_consts.svh"

module pi1_soc import pi1_pkg::*; (
	input  logic                  clk_2x_w,
	input  logic                  rst_p,
	input  pi1_req_t              req_i,
	output pi1_rsp_t              rsp_o,
	input  logic [`GPIOCOUNT-1:0] gp_i,
	output logic [`GPIOCOUNT-1:0] gp_o,
	output logic                  sys_rst_o
);

	pi1_req_t                  devtbl_req_w;
	pi1_req_t                  gpio_req_w;
	logic [`PI1_ARCHBITSZ-1:0] devtbl_rdata_w;
	logic [`PI1_ARCHBITSZ-1:0] gpio_rdata_w;
	logic                      rst0_w;
	logic                      rst1_w;

	reset_seq u_reset_seq (
		.clk_2x_w  (clk_2x_w),
		.rst_p     (rst_p),
		.rst0_i    (rst0_w),
		.rst1_i    (rst1_w),
		.sys_rst_o (sys_rst_o)
	);

	bus_router u_bus_router (
		.clk_2x_w       (clk_2x_w),
		.sys_rst_i      (sys_rst_o),
		.req_i          (req_i),
		.rsp_o          (rsp_o),
		.devtbl_req_o   (devtbl_req_w),
		.gpio_req_o     (gpio_req_w),
		.devtbl_rdata_i (devtbl_rdata_w),
		.gpio_rdata_i   (gpio_rdata_w)
	);

	dev_table u_dev_table (
		.clk_2x_w  (clk_2x_w),
		.sys_rst_i (sys_rst_o),
		.req_i     (devtbl_req_w),
		.rdata_o   (devtbl_rdata_w),
		.rst0_o    (rst0_w),
		.rst1_o    (rst1_w)
	);

	gpio_port u_gpio_port (
		.clk_2x_w  (clk_2x_w),
		.sys_rst_i (sys_rst_o),
		.req_i     (gpio_req_w),
		.rdata_o   (gpio_rdata_w),
		.gp_i      (gp_i),
		.gp_o      (gp_o)
	);

endmodule

// File: soc_checker.sv
`timescale 1ns/10ps
`include "pi1_consts.svh"

module soc_checker import pi1_pkg::*; (
	input  logic                      clk_2x_w,
	input  pi1_req_t                  req_i,
	input  pi1_rsp_t                  rsp_i,
	input  logic                      sys_rst_i,
	input  logic [`GPIOCOUNT-1:0]     gp_i,
	input  logic [`PI1_ARCHBITSZ-1:0] exp_rdata_i,
	input  logic [`GPIOCOUNT-1:0]     exp_gp_i,
	output int                        err_cnt_o
);

	int   err_cnt = 0;
	logic rdy_prev = 1'b0;
	logic rst_prev = 1'b1;

	// Mid-cycle sample, the request seen here was on the bus at the edge just passed
	always @(negedge clk_2x_w) begin
		if (rdy_prev && (req_i.op == pi1_read || req_i.op == pi1_rdwr)
				&& rsp_i.rdata !== exp_rdata_i) begin
			$display("CHECK FAILED at %0t: read of 0x%0h gave 0x%08h, expected 0x%08h",
				$time, req_i.addr, rsp_i.rdata, exp_rdata_i);
			err_cnt++;
		end
		if (rsp_i.rdy !== !sys_rst_i) begin
			$display("CHECK FAILED at %0t: rdy is %b while sys_rst is %b",
				$time, rsp_i.rdy, sys_rst_i);
			err_cnt++;
		end
		// gp_o is compared once a reset has settled for a full cycle
		if (!sys_rst_i && !rst_prev && gp_i !== exp_gp_i) begin
			$display("CHECK FAILED at %0t: gp_o is 0x%02h, expected 0x%02h",
				$time, gp_i, exp_gp_i);
			err_cnt++;
		end
		rdy_prev = rsp_i.rdy;
		rst_prev = sys_rst_i;
	end

	assign err_cnt_o = err_cnt;

endmodule

// File: tb_pi1_soc.sv
`timescale 1ns/10ps
`include "pi1_consts.svh"

module tb_pi1_soc import pi1_pkg::*; ();

	localparam int n_rand = 200;
	localparam int watchdog_cycles = n_rand * 10 + 200;
	localparam logic [`PI1_ADDRBITSZ-1:0] gpio_base = `DEVTBL_MAPSZ;

	logic                      clk_2x_w;
	logic                      rst_p;
	pi1_req_t                  req;
	pi1_rsp_t                  rsp;
	logic [`GPIOCOUNT-1:0]     gp_in;
	logic [`GPIOCOUNT-1:0]     gp_out;
	logic                      sys_rst;
	logic [`PI1_ARCHBITSZ-1:0] exp_rdata;
	logic [`GPIOCOUNT-1:0]     gp_exp;
	logic [`GPIOCOUNT-1:0]     gp_model;
	logic [`GPIOCOUNT-1:0]     gp_in_model;
	int                        chk_errors;
	int                        seq_errors = 0;
	int                        cycles;

	pi1_soc DUT (
		.clk_2x_w  (clk_2x_w),
		.rst_p     (rst_p),
		.req_i     (req),
		.rsp_o     (rsp),
		.gp_i      (gp_in),
		.gp_o      (gp_out),
		.sys_rst_o (sys_rst)
	);

	soc_checker u_checker (
		.clk_2x_w    (clk_2x_w),
		.req_i       (req),
		.rsp_i       (rsp),
		.sys_rst_i   (sys_rst),
		.gp_i        (gp_out),
		.exp_rdata_i (exp_rdata),
		.exp_gp_i    (gp_exp),
		.err_cnt_o   (chk_errors)
	);

	initial begin
		clk_2x_w = 1'b0;
		forever #5 clk_2x_w = ~clk_2x_w;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk_2x_w);
		$display("Timeout: the tests did not finish within %0d cycles", watchdog_cycles);
		$display("TB FAILED");
		$finish;
	end

	// Expected read word from the address map and the table layout
	function automatic logic [31:0] ref_read(input logic [`PI1_ADDRBITSZ-1:0] addr);
		logic [31:0] word;
		word = '0;
		if (addr < gpio_base) begin
			case (addr)
				0: word = `DEVTBL_MAPSZ;
				1: word = (`DEVTBL_USEINTR << 16) | `DEVTBL_ID;
				2: word = `GPIO_MAPSZ;
				3: word = (`GPIO_USEINTR << 16) | `GPIO_ID;
				4: word = `INVALID_MAPSZ;
				5: word = (`INVALID_USEINTR << 16) | `INVALID_ID;
				`DEVTBL_SOCID_OFS: word = `SOCID;
				// Reset control reads zero since a set bit resets the table
				default: word = '0;
			endcase
		end else if (addr == gpio_base + `GPIO_OUT_OFS) begin
			word = {24'd0, gp_model};
		end else if (addr == gpio_base + `GPIO_IN_OFS) begin
			word = {24'd0, gp_in_model};
		end
		return word;
	endfunction

	task automatic report_mismatch(input string msg);
		$display("CHECK FAILED at %0t: %s", $time, msg);
		seq_errors++;
	endtask

	task automatic issue(input pi1_op_e op, input logic [`PI1_ADDRBITSZ-1:0] addr,
			input logic [31:0] data, input logic [3:0] sel);
		@(negedge clk_2x_w);
		req <= '{op: op, addr: addr, data: data, sel: sel};
		if (op == pi1_read || op == pi1_rdwr) begin
			exp_rdata <= ref_read(addr);
		end
		if (op == pi1_write && addr == gpio_base + `GPIO_OUT_OFS && sel[0]) begin
			gp_model = data[`GPIOCOUNT-1:0];
			gp_exp <= data[`GPIOCOUNT-1:0];
		end
	endtask

	task automatic idle();
		@(negedge clk_2x_w);
		req.op <= pi1_noop;
	endtask

	// Counts the cycles for which sys_rst stays high, up to limit
	task automatic measure_reset(input int limit, output int n);
		int waited;
		n = 0;
		waited = 0;
		while (!sys_rst && waited < 4) begin
			@(negedge clk_2x_w);
			waited++;
		end
		while (sys_rst && n < limit) begin
			n++;
			@(negedge clk_2x_w);
		end
	endtask

	task automatic check_release(input int lo, input int hi);
		int n;
		measure_reset(hi + 5, n);
		if (n < lo || n > hi) begin
			report_mismatch($sformatf("sys_rst held %0d cycles, expected %0d to %0d", n, lo, hi));
		end
		if (rsp.rdata !== '0 || gp_out !== '0) begin
			report_mismatch("rdata or gp_o not zero after reset");
		end
		gp_model = '0;
		gp_exp <= '0;
	endtask

	// rst_p spans two rising edges and is released on a falling edge
	task automatic pulse_rst();
		rst_p <= 1'b1;
		repeat (2) @(posedge clk_2x_w);
		@(negedge clk_2x_w);
		rst_p <= 1'b0;
		check_release(15, 15);
	endtask

	task automatic sw_reset(input logic [31:0] ctrl);
		issue(pi1_write, `DEVTBL_RSTCTRL_OFS, ctrl, 4'h1);
		idle();
	endtask

	// Random mix over all slaves, never touching the reset control word
	task automatic random_mix(input int n);
		logic [`PI1_ADDRBITSZ-1:0] addr;
		pi1_op_e                   op;
		for (int i = 0; i < n; i++) begin
			op = pi1_op_e'(2'($urandom_range(0, 3)));
			case ($urandom_range(0, 3))
				0: addr = `PI1_ADDRBITSZ'($urandom_range(0, 14));
				1: addr = gpio_base + `PI1_ADDRBITSZ'($urandom_range(0, 3));
				2: addr = `PI1_ADDRBITSZ'($urandom_range(20, 63));
				default: addr = {1'b1, 29'($urandom)};
			endcase
			issue(op, addr, $urandom, 4'($urandom));
		end
		idle();
	endtask

	initial begin
		void'($urandom(32'ha4b6_d095));
		rst_p = 1'b1;
		req = '0;
		gp_in = '0;
		exp_rdata = '0;
		gp_exp = '0;
		gp_model = '0;
		gp_in_model = '0;
		pulse_rst();
		for (int i = 0; i < `DEVTBL_MAPSZ; i++) begin
			issue(pi1_read, `PI1_ADDRBITSZ'(i), $urandom, 4'hf);
		end
		issue(pi1_write, gpio_base, 32'h0000_00a5, 4'h1);
		issue(pi1_read, gpio_base, '0, 4'hf);
		issue(pi1_write, gpio_base, 32'h0000_003c, 4'he);
		issue(pi1_read, gpio_base, '0, 4'hf);
		idle();
		gp_in <= 8'h96;
		repeat (3) @(negedge clk_2x_w);
		gp_in_model = 8'h96;
		issue(pi1_rdwr, gpio_base + `GPIO_IN_OFS, '0, 4'hf);
		random_mix(n_rand);
		// Warm reset, then cold reset
		issue(pi1_write, gpio_base, 32'h0000_005a, 4'h1);
		sw_reset(32'h2);
		check_release(14, 20);
		issue(pi1_read, `DEVTBL_RSTCTRL_OFS, '0, 4'hf);
		issue(pi1_write, gpio_base, 32'h0000_00c3, 4'h1);
		sw_reset(32'h3);
		check_release(14, 20);
		issue(pi1_read, gpio_base, '0, 4'hf);
		sw_reset(32'h1);
		measure_reset(50, cycles);
		if (cycles != 50) begin
			report_mismatch($sformatf("power-off released after %0d cycles", cycles));
		end
		pulse_rst();
		issue(pi1_read, `PI1_ADDRBITSZ'(3), '0, 4'hf);
		idle();
		repeat (2) @(negedge clk_2x_w);
		$display("Errors: %0d read/port, %0d reset sequence", chk_errors, seq_errors);
		if (chk_errors == 0 && seq_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: pi1_soc.f
+incdir+.
pi1_pkg.sv
reset_seq.sv
bus_router.sv
dev_table.sv
gpio_port.sv
pi1_soc.sv
soc_checker.sv
tb_pi1_soc.sv

// File: Bender.yml
package:
  name: pi1_soc

export_include_dirs:
  - .

sources:
  - files:
      - pi1_pkg.sv
      - reset_seq.sv
      - bus_router.sv
      - dev_table.sv
      - gpio_port.sv
      - pi1_soc.sv
  - target: test
    files:
      - soc_checker.sv
      - tb_pi1_soc.sv
